// ==== include/loader_defs.svh ====
// Program loader definitions
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// Widths
`define INSTR_W      32     // Instruction word
`define ADDR_W       7      // Instruction memory address
`define DIV_W        32     // Step divider counter
`define SEL_W        3      // Step rate select
`define SLOW_OFFSET  18     // First tap of the slow range
`define PROG_SEL_W   1      // Program select

// Program lengths, sized to the address width
`define N_PROG0      7'd27  // Branching C program
`define N_PROG1      7'd25  // Every-operation program

// Opcodes
`define OP_REG       6'd0   // Register format
`define OP_JMP       6'd2
`define OP_BGT       6'd7
`define OP_ADDI      6'd8
`define OP_SLTI      6'd10
`define OP_ANDI      6'd12
`define OP_ORI       6'd13
`define OP_XORI      6'd14
`define OP_SLLI      6'd15
`define OP_LW        6'd35
`define OP_SW        6'd43

// ALU function codes
`define FN_NOP       6'd0
`define FN_SLLV      6'd4
`define FN_JR        6'd8
`define FN_ADD       6'd32
`define FN_SUB       6'd34
`define FN_AND       6'd36
`define FN_OR        6'd37
`define FN_XOR       6'd38
`define FN_SLT       6'd42

// Register file names
`define R_ZERO       5'd0   // Hardwired zero
`define R_T0         5'd8   // Temporaries
`define R_T1         5'd9
`define R_T2         5'd10

// Register format shift field filler
`define SHAMT_FILL   5'd31

// Data memory locations of the C variables
`define VAR_A        16'd0
`define VAR_B        16'd1
`define VAR_C        16'd2
`define VAR_D        16'd3
`define VAR_DPTR     16'd4

`endif

// ==== src/loader_pkg.sv ====
// Program loader types
`default_nettype none

`include "loader_defs.svh"

package loader_pkg;

   // Immediate format
   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;          // Operand register
      logic [4:0]  rt;          // Destination register
      logic [15:0] imm;         // Immediate or memory address
   } imm_fmt_t;

   // Register format
   typedef struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;           // First operand
      logic [4:0] rt;           // Second operand
      logic [4:0] rd;           // Destination
      logic [4:0] shamt;        // Filled with ones
      logic [5:0] funct;        // ALU function
   } rtype_fmt_t;

   // Jump format
   typedef struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;      // Instruction address
   } jmp_fmt_t;

   // One instruction word, three decodes
   typedef union packed {
      imm_fmt_t   imm;
      rtype_fmt_t rtype;
      jmp_fmt_t   jmp;
   } instr_word_t;

   // Instruction memory write port
   typedef struct packed {
      logic                 wr_en;
      logic [`ADDR_W-1:0]   addr;
      instr_word_t          data;
   } prog_write_t;

   // Computer control, both active low
   typedef struct packed {
      logic comp_rst;           // Held in reset while 0
      logic comp_en;            // Runs while 0
   } comp_ctrl_t;

   typedef enum logic [1:0] {
      IDLE          = 2'b00,
      WRITE_PROGRAM = 2'b01,
      RUN_PROGRAM   = 2'b10
   } load_state_t;

endpackage

`default_nettype wire

// ==== src/step_divider.sv ====
// Step enable divider
`timescale 1ns/10ps
`default_nettype none

`include "loader_defs.svh"

module step_divider (
   input  wire logic              clk,
   input  wire logic              reset_sm,
   input  wire logic              clk_speed,   // 1 selects the fast range
   input  wire logic [`SEL_W-1:0] clk_select,  // Tap within the range
   output      logic              step         // One cycle per period
);

   logic [`DIV_W-1:0] count;                   // Free-running
   logic [4:0]        tap;                     // Period is 2^tap cycles
   logic [`DIV_W-1:0] mask;                    // Bits below the tap

   // Fast range taps 0..7, slow range shifted up
   assign tap = clk_speed ? 5'(clk_select)
                          : 5'(clk_select) + 5'(`SLOW_OFFSET);

   assign mask = (`DIV_W'(1) << tap) - `DIV_W'(1);

   // All bits below tap set, i.e. last cycle of the period
   assign step = ((count & mask) == mask);     // Tap 0 gives every cycle

   always_ff @(posedge clk or negedge reset_sm) begin
      if (!reset_sm) begin
         count <= '0;
      end else begin
         count <= count + `DIV_W'(1);          // Wraps freely
      end
   end

endmodule

`default_nettype wire

// ==== src/program_rom.sv ====
// Stored program ROM
`timescale 1ns/10ps
`default_nettype none

`include "loader_defs.svh"

module program_rom (
   input  wire logic [`PROG_SEL_W-1:0] prog_sel,
   input  wire logic [`ADDR_W-1:0]     index,
   output      loader_pkg::instr_word_t word,
   output      logic [`ADDR_W-1:0]     length
);

   import loader_pkg::*;

   instr_word_t word0;                         // Program 0 entry
   instr_word_t word1;                         // Program 1 entry

   // Immediate format word
   function automatic instr_word_t i_fmt(input logic [5:0]  op,
                                         input logic [4:0]  rs,
                                         input logic [4:0]  rt,
                                         input logic [15:0] imm);
      instr_word_t w;
      w.imm.opcode = op;
      w.imm.rs     = rs;
      w.imm.rt     = rt;
      w.imm.imm    = imm;
      return w;
   endfunction

   // Register format word, shift field always filled
   function automatic instr_word_t r_fmt(input logic [4:0] rs,
                                         input logic [4:0] rt,
                                         input logic [4:0] rd,
                                         input logic [5:0] fn);
      instr_word_t w;
      w.rtype.opcode = `OP_REG;
      w.rtype.rs     = rs;
      w.rtype.rt     = rt;
      w.rtype.rd     = rd;
      w.rtype.shamt  = `SHAMT_FILL;
      w.rtype.funct  = fn;
      return w;
   endfunction

   // Jump format word
   function automatic instr_word_t j_fmt(input logic [25:0] target);
      instr_word_t w;
      w.jmp.opcode = `OP_JMP;
      w.jmp.target = target;
      return w;
   endfunction

   // Program 0, if (A - B) > 3 branch
   always_comb begin
      word0 = '0;                               // Past the end reads zero
      case (index)
         7'd0:  word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd7);   // A = 7
         7'd1:  word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_A);
         7'd2:  word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd5);   // B = 5
         7'd3:  word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_B);
         7'd4:  word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd2);   // C = 2
         7'd5:  word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_C);
         7'd6:  word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd4);   // D = 4
         7'd7:  word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_D);
         7'd8:  word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, `VAR_D);  // DPtr = &D
         7'd9:  word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_DPTR);
         7'd10: word0 = i_fmt(`OP_LW,   `R_ZERO, `R_T0, `VAR_A);  // Load A, B
         7'd11: word0 = i_fmt(`OP_LW,   `R_ZERO, `R_T1, `VAR_B);
         7'd12: word0 = r_fmt(`R_T0, `R_T1, `R_T0, `FN_SUB);      // A - B
         7'd13: word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd3);   // Threshold
         7'd14: word0 = i_fmt(`OP_BGT,  `R_T0,   `R_T1, 16'd6);   // To else part
         7'd15: word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd6);   // C = 6
         7'd16: word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_C);
         7'd17: word0 = i_fmt(`OP_LW,   `R_ZERO, `R_T0, `VAR_D);  // D = D << 2
         7'd18: word0 = i_fmt(`OP_SLLI, `R_T0,   `R_T0, 16'd2);
         7'd19: word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_D);
         7'd20: word0 = j_fmt(26'd27);                            // Skip else part
         7'd21: word0 = i_fmt(`OP_LW,   `R_ZERO, `R_T0, `VAR_C);  // C = C << 5
         7'd22: word0 = i_fmt(`OP_SLLI, `R_T0,   `R_T0, 16'd5);
         7'd23: word0 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_C);
         7'd24: word0 = i_fmt(`OP_LW,   `R_ZERO, `R_T0, `VAR_DPTR); // *DPtr = 7
         7'd25: word0 = i_fmt(`OP_ADDI, `R_ZERO, `R_T1, 16'd7);
         7'd26: word0 = i_fmt(`OP_SW,   `R_T0,   `R_T1, 16'd0);   // Indirect store
         default: word0 = '0;
      endcase
   end

   // Program 1, every ALU operation once
   always_comb begin
      word1 = '0;
      case (index)
         7'd0:  word1 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd10);  // t0 = 10
         7'd1:  word1 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_A);
         7'd2:  word1 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd3);   // t0 = 3
         7'd3:  word1 = i_fmt(`OP_SW,   `R_ZERO, `R_T0, `VAR_B);
         7'd4:  word1 = i_fmt(`OP_LW,   `R_ZERO, `R_T0, `VAR_A);  // t0 = 10
         7'd5:  word1 = i_fmt(`OP_LW,   `R_ZERO, `R_T1, `VAR_B);  // t1 = 3
         7'd6:  word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_ADD);      // 13
         7'd7:  word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_SUB);      // 7
         7'd8:  word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_AND);      // 2
         7'd9:  word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_OR);       // 11
         7'd10: word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_XOR);      // 9
         7'd11: word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_SLT);      // 0
         7'd12: word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_SLLV);     // 80
         7'd13: word1 = i_fmt(`OP_ADDI, `R_ZERO, `R_T0, 16'd18);  // Jump target
         7'd14: word1 = r_fmt(`R_T0, `R_ZERO, `R_ZERO, `FN_JR);   // Over the NOPs
         7'd15: word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_NOP);
         7'd16: word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_NOP);
         7'd17: word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_NOP);
         7'd18: word1 = r_fmt(`R_T0, `R_T1, `R_T2, `FN_NOP);
         7'd19: word1 = i_fmt(`OP_ADDI, `R_T0, `R_T2, 16'd3);     // 21
         7'd20: word1 = i_fmt(`OP_SLTI, `R_T0, `R_T2, 16'd3);     // 0
         7'd21: word1 = i_fmt(`OP_ANDI, `R_T0, `R_T2, 16'd3);     // 2
         7'd22: word1 = i_fmt(`OP_ORI,  `R_T0, `R_T2, 16'd3);     // 19
         7'd23: word1 = i_fmt(`OP_XORI, `R_T0, `R_T2, 16'd3);     // 17
         7'd24: word1 = i_fmt(`OP_SLLI, `R_T0, `R_T2, 16'd3);     // 144
         default: word1 = '0;
      endcase
   end

   assign word   = prog_sel[0] ? word1 : word0;
   assign length = prog_sel[0] ? `N_PROG1 : `N_PROG0;

endmodule

`default_nettype wire

// ==== src/load_sequencer.sv ====
// Program load sequencer
`timescale 1ns/10ps
`default_nettype none

`include "loader_defs.svh"

module load_sequencer (
   input  wire logic                    clk,
   input  wire logic                    reset_sm,
   input  wire logic                    step,            // Advance enable
   input  wire logic                    next_state,      // Push button, active low
   input  wire logic [`PROG_SEL_W-1:0]  program_select,
   input  wire loader_pkg::instr_word_t word,            // ROM word at index
   input  wire logic [`ADDR_W-1:0]      length,          // Words in program
   output      logic [`ADDR_W-1:0]      index,           // Next word to write
   output      logic [`PROG_SEL_W-1:0]  prog_sel,        // Latched at press
   output      loader_pkg::comp_ctrl_t  comp_ctrl,
   output      loader_pkg::prog_write_t prog_write
);

   import loader_pkg::*;

   load_state_t state;
   logic        btn_prev;                      // Button level at last step
   logic        press;

   // Falling edge of the button, sampled on steps
   assign press = !next_state && btn_prev;

   always_ff @(posedge clk or negedge reset_sm) begin
      if (!reset_sm) begin
         state              <= IDLE;
         btn_prev           <= 1'b0;
         index              <= '0;
         prog_sel           <= '0;
         comp_ctrl.comp_rst <= 1'b0;           // Computer held in reset
         comp_ctrl.comp_en  <= 1'b1;           // and stopped
         prog_write         <= '0;
      end else if (step) begin
         btn_prev <= next_state;

         case (state)
            IDLE: begin
               comp_ctrl.comp_rst <= 1'b0;
               if (press) begin
                  prog_sel           <= program_select;  // Fixed for the load
                  comp_ctrl.comp_rst <= 1'b1;            // Release reset
                  state              <= WRITE_PROGRAM;
               end
            end

            WRITE_PROGRAM: begin
               if (index < length) begin
                  prog_write.wr_en <= 1'b1;    // One word per step
                  prog_write.addr  <= index;
                  prog_write.data  <= word;
                  index            <= index + `ADDR_W'(1);
               end else begin
                  prog_write.wr_en <= 1'b0;    // Last word done
                  state            <= RUN_PROGRAM;
               end
            end

            RUN_PROGRAM: begin
               comp_ctrl.comp_en <= 1'b0;      // Start, until reset
            end

            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== src/program_loader.sv ====
// Program loader top level
`timescale 1ns/10ps
`default_nettype none

`include "loader_defs.svh"

module program_loader (
   input  wire logic                    clk,
   input  wire logic                    reset_sm,
   input  wire logic                    next_state,      // Push button, active low
   input  wire logic                    clk_speed,
   input  wire logic [`SEL_W-1:0]       clk_select,
   input  wire logic [`PROG_SEL_W-1:0]  program_select,
   output      logic                    step,            // Computer clock enable
   output      loader_pkg::comp_ctrl_t  comp_ctrl,
   output      loader_pkg::prog_write_t prog_write
);

   import loader_pkg::*;

   logic [`ADDR_W-1:0]     index;              // Sequencer to ROM
   logic [`PROG_SEL_W-1:0] prog_sel;           // Latched choice
   instr_word_t            word;
   logic [`ADDR_W-1:0]     length;

   step_divider u_step_divider (
      .clk        (clk),
      .reset_sm   (reset_sm),
      .clk_speed  (clk_speed),
      .clk_select (clk_select),
      .step       (step)
   );

   program_rom u_program_rom (
      .prog_sel (prog_sel),
      .index    (index),
      .word     (word),
      .length   (length)
   );

   load_sequencer u_load_sequencer (
      .clk            (clk),
      .reset_sm       (reset_sm),
      .step           (step),
      .next_state     (next_state),
      .program_select (program_select),
      .word           (word),
      .length         (length),
      .index          (index),
      .prog_sel       (prog_sel),
      .comp_ctrl      (comp_ctrl),
      .prog_write     (prog_write)
   );

endmodule

`default_nettype wire

// ==== verification/program_loader_checks.sv ====
// Program loader checks
`timescale 1ns/10ps
`default_nettype none

`include "loader_defs.svh"

module program_loader_checks (
   input  wire logic                    clk,
   input  wire logic                    reset_sm,
   input  wire logic                    next_state,
   input  wire logic                    clk_speed,
   input  wire logic [`SEL_W-1:0]       clk_select,
   input  wire logic [`PROG_SEL_W-1:0]  program_select,
   input  wire logic                    step,
   input  wire loader_pkg::comp_ctrl_t  comp_ctrl,
   input  wire loader_pkg::prog_write_t prog_write,
   output      int                      errors,
   output      int                      writes,
   output      int                      loads
);

   import loader_pkg::*;

   int                     error_count = 0;    // Kept across resets
   int                     write_count = 0;
   int                     load_count  = 0;
   logic                   active;             // Press taken since reset
   logic                   btn_prev;           // Button at last step
   logic                   en_fell;            // Run state reached
   logic [`PROG_SEL_W-1:0] exp_prog;           // Program latched at press
   int                     exp_addr;           // Next address expected
   int                     since_step;         // Cycles since last step
   int                     cyc;
   int                     last_write;
   int                     period;             // Cycles per step
   int                     length;
   logic [32:0]            gold;               // Valid bit and word

   assign errors = error_count;
   assign writes = write_count;
   assign loads  = load_count;

   task automatic report_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("Fail %s: got %h expected %h", name, got, exp);
      error_count++;
   endtask

   task automatic report_event(input string msg);
      $display("Error: %s", msg);
      error_count++;
   endtask

   function automatic logic known_opcode(input logic [5:0] op);
      case (op)
         `OP_REG, `OP_JMP, `OP_BGT, `OP_ADDI, `OP_SLTI, `OP_ANDI,
         `OP_ORI, `OP_XORI, `OP_SLLI, `OP_LW, `OP_SW: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Hand-assembled reference words by program and address
   function automatic logic [32:0] golden_word(input logic prog, input int addr);
      case ({prog, 7'(addr)})
         8'h00:   return {1'b1, 32'h20080007};     // addi t0, zero, 7
         8'h01:   return {1'b1, 32'hAC080000};     // sw t0, A
         8'h0C:   return {1'b1, 32'h010947E2};     // sub t0, t0, t1
         8'h14:   return {1'b1, 32'h0800001B};     // j 27
         8'h8E:   return {1'b1, 32'h010007C8};     // jr t0
         default: return '0;
      endcase
   endfunction

   always @(negedge clk) begin
      period = 1 << (clk_speed ? int'(clk_select) : int'(clk_select) + `SLOW_OFFSET);
      length = exp_prog[0] ? 25 : 27;           // Word counts of programs 1 and 0
      if (!reset_sm) begin
         active     = 1'b0;
         btn_prev   = 1'b0;                     // Matches sequencer reset
         en_fell    = 1'b0;
         exp_prog   = '0;
         exp_addr   = 0;
         since_step = 0;                        // Divider restarts at zero
         cyc        = 0;
         last_write = 0;
      end else begin
         if (step) begin
            assert (since_step == period - 1)
               else report_value("step spacing", since_step + 1, period);
            since_step = 0;
         end else begin
            assert (since_step < period - 1)
               else report_event("no step at the end of the divider period");
            since_step++;
         end
         if (!active) begin                     // Idle with the computer held
            assert (comp_ctrl.comp_rst == 1'b0)
               else report_value("comp_rst", comp_ctrl.comp_rst, 0);
            assert (comp_ctrl.comp_en == 1'b1)
               else report_value("comp_en", comp_ctrl.comp_en, 1);
            assert (prog_write.wr_en == 1'b0)
               else report_value("prog_write.wr_en", prog_write.wr_en, 0);
         end else begin
            assert (comp_ctrl.comp_rst == 1'b1)
               else report_value("comp_rst", comp_ctrl.comp_rst, 1);
         end
         if (en_fell) begin
            assert (comp_ctrl.comp_en == 1'b0)
               else report_event("computer enable released after the run started");
            assert (prog_write.wr_en == 1'b0)
               else report_event("write enable high in the run state");
         end else if (active && !comp_ctrl.comp_en) begin
            assert (exp_addr == length)
               else report_value("write count", exp_addr, length);
            en_fell = 1'b1;
            load_count++;
         end
         if (active && step && prog_write.wr_en) begin  // Write taken by computer
            gold = golden_word(exp_prog[0], exp_addr);
            assert (exp_addr < length)
               else report_event("write past the end of the program");
            assert (int'(prog_write.addr) == exp_addr)
               else report_value("prog_write.addr", prog_write.addr, exp_addr);
            assert (!gold[32] || prog_write.data == gold[31:0])
               else report_value("prog_write.data", prog_write.data, gold[31:0]);
            assert (known_opcode(prog_write.data.imm.opcode))
               else report_event("write carries an unknown opcode");
            if (prog_write.data.rtype.opcode == `OP_REG) begin
               assert (prog_write.data.rtype.shamt == `SHAMT_FILL)
                  else report_value("prog_write.data.rtype.shamt",
                                    prog_write.data.rtype.shamt, `SHAMT_FILL);
            end
            if (exp_addr > 0) begin
               assert (cyc - last_write == period)
                  else report_value("write spacing", cyc - last_write, period);
            end
            last_write = cyc;
            exp_addr++;
            write_count++;
         end
         if (step) begin                        // Sequencer samples at this edge
            if (!active && !next_state && btn_prev) begin
               active   = 1'b1;
               exp_prog = program_select;
            end
            btn_prev = next_state;
         end
         cyc++;
      end
   end

endmodule

`default_nettype wire

// ==== verification/program_loader_tb.sv ====
// Program loader testbench
`timescale 1ns/10ps
`default_nettype none

`include "loader_defs.svh"

module program_loader_tb;

   import loader_pkg::*;

   localparam int TIMEOUT_CYCLES = 2000;        // Four loads of at most 29 steps, 4 cycles

   logic                   clk;
   logic                   reset_sm;
   logic                   next_state;         // Button, active low
   logic                   clk_speed;
   logic [`SEL_W-1:0]      clk_select;
   logic [`PROG_SEL_W-1:0] program_select;
   logic                   step;
   comp_ctrl_t             comp_ctrl;
   prog_write_t            prog_write;
   logic [31:0]            rand_state;
   logic                   first_prog;
   int                     cycles;
   int                     errors;
   int                     writes;
   int                     loads;
   int                     run;

   program_loader u_program_loader (
      .clk            (clk),
      .reset_sm       (reset_sm),
      .next_state     (next_state),
      .clk_speed      (clk_speed),
      .clk_select     (clk_select),
      .program_select (program_select),
      .step           (step),
      .comp_ctrl      (comp_ctrl),
      .prog_write     (prog_write)
   );

   program_loader_checks u_checks (
      .clk            (clk),
      .reset_sm       (reset_sm),
      .next_state     (next_state),
      .clk_speed      (clk_speed),
      .clk_select     (clk_select),
      .program_select (program_select),
      .step           (step),
      .comp_ctrl      (comp_ctrl),
      .prog_write     (prog_write),
      .errors         (errors),
      .writes         (writes),
      .loads          (loads)
   );

   always #20 clk = ~clk;                       // 40 ns period

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a load never reached the run state", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic apply_reset(input logic [`SEL_W-1:0] sel, input logic prog);
      @(posedge clk);
      reset_sm       <= 1'b0;
      next_state     <= 1'b1;
      clk_speed      <= 1'b1;                   // Fast range only
      clk_select     <= sel;
      program_select <= prog;
      wait_cycles(4);
      reset_sm       <= 1'b1;
   endtask

   task automatic push_button(input int hold);
      next_state <= 1'b0;
      wait_cycles(hold);                        // Spans at least one step
      next_state <= 1'b1;
   endtask

   task automatic load_program(input logic prog, input logic [`SEL_W-1:0] sel);
      int period;
      int hold;
      int change;
      period     = 1 << sel;
      rand_state = lcg_next(rand_state);
      hold       = period * (1 + int'(rand_state[17:16]) % 3);
      rand_state = lcg_next(rand_state);
      change     = 1 + int'(rand_state[23:16]) % (period * 8);
      apply_reset(sel, prog);
      wait_cycles(2 * period);                  // Button seen high first
      push_button(hold);
      @(negedge clk);
      while (!comp_ctrl.comp_rst) @(negedge clk);
      @(posedge clk);
      wait_cycles(change);
      program_select <= ~prog;                  // Mid-load, after latch
      @(negedge clk);
      while (comp_ctrl.comp_en) @(negedge clk); // Computer started
      @(posedge clk);
      wait_cycles(2 * period);
      push_button(2 * period);                  // Ignored while running
      wait_cycles(4 * period);
   endtask

   initial begin
      clk            = 1'b0;
      reset_sm       = 1'b0;
      next_state     = 1'b1;
      clk_speed      = 1'b1;
      clk_select     = '0;
      program_select = '0;
      cycles         = 0;
      rand_state     = 32'h29a7;
      rand_state     = lcg_next(rand_state);
      first_prog     = rand_state[16];
      for (run = 0; run < 4; run++) begin       // Each program at tap 0, then tap 2
         load_program(first_prog ^ run[0], (run < 2) ? 3'd0 : 3'd2);
      end
      $display("Done: %0d loads, %0d writes, %0d errors", loads, writes, errors);
      if (errors == 0 && loads == 4) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== program_loader.f ====
+incdir+include
src/loader_pkg.sv
src/step_divider.sv
src/program_rom.sv
src/load_sequencer.sv
src/program_loader.sv
verification/program_loader_checks.sv
verification/program_loader_tb.sv
